// File: design/soc_pkg.sv
/*
  Shared bus types and memory map of the SoC interconnect.
  All targets are 32 bits wide, so no width conversion exists anywhere.
*/
`default_nettype none

package soc_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [SelWidth-1:0]  sel_t;

  ////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////

  localparam addr_t L2Base     = 32'h8000_0000;
  localparam addr_t L2Length   = 32'h4000_0000;
  localparam addr_t UartBase   = 32'hC000_0000;
  localparam addr_t UartLength = 32'h0000_1000;
  localparam addr_t CtrlBase   = 32'hD000_0000;
  localparam addr_t CtrlLength = 32'h0000_1000;

  // Control register offsets within the CTRL window
  localparam logic [11:0] CtrlExitOffset     = 12'h000;
  localparam logic [11:0] CtrlDramBaseOffset = 12'h004;
  localparam logic [11:0] CtrlDramEndOffset  = 12'h008;

  ////////////////////////////////////////
  // Wishbone classic and APB
  ////////////////////////////////////////

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
    sel_t  sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS,
    APB_DONE
  } apb_state_e;

endpackage : soc_pkg

`default_nettype wire

// File: design/soc_xbar.sv
/*
  Single-master Wishbone decoder. Only one access may be in flight.
  Unmapped addresses end in err one cycle later with zero read data.
*/
`timescale 1ns/1ps
`default_nettype none

module soc_xbar (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t mst_req_i,
  output soc_pkg::wb_rsp_t mst_rsp_o,
  output soc_pkg::wb_req_t l2_req_o,
  output soc_pkg::wb_req_t uart_req_o,
  output soc_pkg::wb_req_t ctrl_req_o,
  input  soc_pkg::wb_rsp_t l2_rsp_i,
  input  soc_pkg::wb_rsp_t uart_rsp_i,
  input  soc_pkg::wb_rsp_t ctrl_rsp_i
);
  import soc_pkg::*;

  target_e tgt;
  logic    err_q;

  function automatic logic in_window(addr_t addr, addr_t base, addr_t len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  always_comb begin
    tgt = TGT_NONE;
    if (in_window(mst_req_i.adr, L2Base, L2Length)) begin
      tgt = TGT_L2;
    end else if (in_window(mst_req_i.adr, UartBase, UartLength)) begin
      tgt = TGT_UART;
    end else if (in_window(mst_req_i.adr, CtrlBase, CtrlLength)) begin
      tgt = TGT_CTRL;
    end
  end

  // Only the selected target sees stb
  always_comb begin
    l2_req_o       = mst_req_i;
    uart_req_o     = mst_req_i;
    ctrl_req_o     = mst_req_i;
    l2_req_o.stb   = mst_req_i.stb && (tgt == TGT_L2);
    uart_req_o.stb = mst_req_i.stb && (tgt == TGT_UART);
    ctrl_req_o.stb = mst_req_i.stb && (tgt == TGT_CTRL);
  end

  // Error responder for holes in the map
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= mst_req_i.cyc && mst_req_i.stb && (tgt == TGT_NONE) && !err_q;
    end
  end

  ////////////////////////////////////////
  // Response select
  ////////////////////////////////////////

  always_comb begin
    mst_rsp_o = '0;
    unique case (tgt)
      TGT_L2:   mst_rsp_o = l2_rsp_i;
      TGT_UART: mst_rsp_o = uart_rsp_i;
      TGT_CTRL: mst_rsp_o = ctrl_rsp_i;
      default:  mst_rsp_o.err = err_q;
    endcase
  end

endmodule : soc_xbar

`default_nettype wire

// File: design/l2_mem.sv
/*
  Word SRAM with byte selects and one cycle of latency.
  L2NumWords must be a power of two, at least 2; higher address bits alias.
*/
`timescale 1ns/1ps
`default_nettype none

module l2_mem #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o
);
  import soc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(L2NumWords);
  localparam int unsigned OffWidth = $clog2(SelWidth);

  data_t                mem [L2NumWords];
  logic  [IdxWidth-1:0] idx;
  logic                 access;
  logic                 ack_q;
  data_t                rdata_q;

  assign idx    = wb_req_i.adr[OffWidth +: IdxWidth];
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (wb_req_i.we) begin
        for (int b = 0; b < SelWidth; b++) begin
          if (wb_req_i.sel[b]) begin
            mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;

endmodule : l2_mem

`default_nettype wire

// File: design/wb_to_apb.sv
/*
  Wishbone to APB bridge for the UART window.
  APB has no strobes: writes always send the full word and sel is ignored.
*/
`timescale 1ns/1ps
`default_nettype none

module wb_to_apb (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::wb_req_t  wb_req_i,
  output soc_pkg::wb_rsp_t  wb_rsp_o,
  output soc_pkg::apb_req_t apb_req_o,
  input  soc_pkg::apb_rsp_t apb_rsp_i
);
  import soc_pkg::*;

  apb_state_e state_q;
  apb_state_e state_d;
  logic       start;
  addr_t      addr_q;
  data_t      wdata_q;
  logic       write_q;
  data_t      rdata_q;
  logic       slverr_q;

  assign start = wb_req_i.cyc && wb_req_i.stb;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      APB_IDLE: begin
        if (start) begin
          state_d = APB_SETUP;
        end
      end
      APB_SETUP: state_d = APB_ACCESS;
      APB_ACCESS: begin
        // Wait states stretch this phase
        if (apb_rsp_i.pready) begin
          state_d = APB_DONE;
        end
      end
      default: state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == APB_IDLE && start) begin
      addr_q  <= wb_req_i.adr;
      wdata_q <= wb_req_i.dat;
      write_q <= wb_req_i.we;
    end
    if (state_q == APB_ACCESS && apb_rsp_i.pready) begin
      rdata_q  <= apb_rsp_i.prdata;
      slverr_q <= apb_rsp_i.pslverr;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign apb_req_o.psel    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
  assign apb_req_o.penable = (state_q == APB_ACCESS);
  assign apb_req_o.pwrite  = write_q;
  assign apb_req_o.paddr   = addr_q;
  assign apb_req_o.pwdata  = wdata_q;

  assign wb_rsp_o.ack = (state_q == APB_DONE) && !slverr_q;
  assign wb_rsp_o.err = (state_q == APB_DONE) && slverr_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule : wb_to_apb

`default_nettype wire

// File: design/ctrl_registers.sv
/*
  Control registers: exit code plus read-only DRAM base and end.
  Only the low 12 address bits are decoded; unknown offsets read zero.
*/
`timescale 1ns/1ps
`default_nettype none

module ctrl_registers (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output soc_pkg::data_t   exit_o
);
  import soc_pkg::*;

  logic [11:0] offset;
  logic        access;
  logic        ack_q;
  data_t       exit_q;
  data_t       rdata_d;
  data_t       rdata_q;

  assign offset = wb_req_i.adr[11:0];
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  always_comb begin
    case (offset)
      CtrlExitOffset:     rdata_d = exit_q;
      CtrlDramBaseOffset: rdata_d = L2Base;
      CtrlDramEndOffset:  rdata_d = L2Base + L2Length;
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      exit_q <= '0;
    end else begin
      ack_q <= access;
      // Writes elsewhere are acked and dropped
      if (access && wb_req_i.we && offset == CtrlExitOffset) begin
        for (int b = 0; b < SelWidth; b++) begin
          if (wb_req_i.sel[b]) begin
            exit_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !wb_req_i.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;
  assign exit_o       = exit_q;

endmodule : ctrl_registers

`default_nettype wire

// File: design/soc_top.sv
/*
  SoC interconnect top: one Wishbone master, L2, UART over APB, CTRL.
  The master must keep a single access in flight at a time.
*/
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::wb_req_t  wb_req_i,
  output soc_pkg::wb_rsp_t  wb_rsp_o,
  output soc_pkg::apb_req_t apb_req_o,
  input  soc_pkg::apb_rsp_t apb_rsp_i,
  output soc_pkg::data_t    exit_o
);
  import soc_pkg::*;

  wb_req_t l2_req;
  wb_req_t uart_req;
  wb_req_t ctrl_req;
  wb_rsp_t l2_rsp;
  wb_rsp_t uart_rsp;
  wb_rsp_t ctrl_rsp;

  soc_xbar i_soc_xbar (
    .clk_i     (clk_i   ),
    .rst_n_i   (rst_n_i ),
    .mst_req_i (wb_req_i),
    .mst_rsp_o (wb_rsp_o),
    .l2_req_o  (l2_req  ),
    .uart_req_o(uart_req),
    .ctrl_req_o(ctrl_req),
    .l2_rsp_i  (l2_rsp  ),
    .uart_rsp_i(uart_rsp),
    .ctrl_rsp_i(ctrl_rsp)
  );

  l2_mem #(
    .L2NumWords(L2NumWords)
  ) i_l2_mem (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .wb_req_i(l2_req ),
    .wb_rsp_o(l2_rsp )
  );

  wb_to_apb i_wb_to_apb (
    .clk_i    (clk_i    ),
    .rst_n_i  (rst_n_i  ),
    .wb_req_i (uart_req ),
    .wb_rsp_o (uart_rsp ),
    .apb_req_o(apb_req_o),
    .apb_rsp_i(apb_rsp_i)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i   (clk_i   ),
    .rst_n_i (rst_n_i ),
    .wb_req_i(ctrl_req),
    .wb_rsp_o(ctrl_rsp),
    .exit_o  (exit_o  )
  );

endmodule : soc_top

`default_nettype wire

// File: sim/soc_props.sv
/*
  Bus protocol assertions for soc_top, attached with bind.
  Covers the external Wishbone port and the APB port of the UART bridge.
*/
`timescale 1ns/1ps
`default_nettype none

module soc_props (
  input logic              clk_i,
  input logic              rst_n_i,
  input soc_pkg::wb_req_t  wb_req_i,
  input soc_pkg::wb_rsp_t  wb_rsp_i,
  input soc_pkg::apb_req_t apb_req_i,
  input soc_pkg::apb_rsp_t apb_rsp_i
);

  ////////////////////////////////////////
  // Wishbone
  ////////////////////////////////////////

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_rsp_i.ack && wb_rsp_i.err))
    else $error("ack and err high in the same cycle");

  rsp_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_rsp_i.ack || wb_rsp_i.err) |-> (wb_req_i.cyc && wb_req_i.stb))
    else $error("response without an active strobe");

  ////////////////////////////////////////
  // APB
  ////////////////////////////////////////

  penable_has_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_req_i.penable |-> apb_req_i.psel)
    else $error("penable high while psel is low");

  setup_then_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (apb_req_i.psel && !apb_req_i.penable) |=> apb_req_i.penable)
    else $error("setup phase not followed by access phase");

  // Transfer held until the target is ready
  hold_until_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (apb_req_i.psel && !apb_rsp_i.pready) |=>
      (apb_req_i.psel && $stable(apb_req_i.paddr) && $stable(apb_req_i.pwdata)))
    else $error("APB transfer changed before pready");

endmodule : soc_props

bind soc_top soc_props i_soc_props (
  .clk_i    (clk_i    ),
  .rst_n_i  (rst_n_i  ),
  .wb_req_i (wb_req_i ),
  .wb_rsp_i (wb_rsp_o ),
  .apb_req_i(apb_req_o),
  .apb_rsp_i(apb_rsp_i)
);

`default_nettype wire

// File: sim/soc_tb.sv
/*
  Testbench for soc_top: a table of Wishbone accesses and an APB target model.
  The APB model waits 0 to 3 cycles and flags pslverr at UartBase+0xFFC.
*/
`timescale 1ns/1ps
`default_nettype none

module soc_tb;
  import soc_pkg::*;

  localparam int unsigned L2NumWords    = 1024;
  localparam int unsigned TimeoutCycles = 50;
  localparam data_t       PrdataMask    = 32'hA5A5_0000;

  typedef enum logic [1:0] {
    K_WRITE,
    K_READ,
    K_EXIT
  } kind_e;

  typedef struct packed {
    kind_e kind;
    addr_t addr;
    data_t wdata;
    sel_t  sel;
    data_t rdata;
    logic  err;
  } vec_t;

  logic     clk_i;
  logic     rst_n_i;
  wb_req_t  wb_req_i;
  wb_rsp_t  wb_rsp_o;
  apb_req_t apb_req_o;
  apb_rsp_t apb_rsp_i;
  data_t    exit_o;

  vec_t     vecs[$];
  apb_req_t apb_writes[$];
  int       apb_xfers;
  int       wait_left;
  int       mismatches;
  int       timeouts;

  soc_top #(
    .L2NumWords(L2NumWords)
  ) soc_top_i (
    .clk_i    (clk_i    ),
    .rst_n_i  (rst_n_i  ),
    .wb_req_i (wb_req_i ),
    .wb_rsp_o (wb_rsp_o ),
    .apb_req_o(apb_req_o),
    .apb_rsp_i(apb_rsp_i),
    .exit_o   (exit_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // APB target model
  ////////////////////////////////////////

  initial begin
    apb_rsp_i = '0;
    apb_xfers = 0;
    wait_left = 0;
    forever begin
      @(negedge clk_i);
      apb_rsp_i = '0;
      if (apb_req_o.psel && !apb_req_o.penable) begin
        wait_left = $urandom_range(3, 0);
        apb_xfers++;
      end else if (apb_req_o.psel && apb_req_o.penable) begin
        if (wait_left == 0) begin
          apb_rsp_i.pready  = 1'b1;
          apb_rsp_i.prdata  = apb_req_o.paddr ^ PrdataMask;
          apb_rsp_i.pslverr = (apb_req_o.paddr == UartBase + 32'hFFC);
          if (apb_req_o.pwrite) begin
            apb_writes.push_back(apb_req_o);
          end
        end else begin
          wait_left--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_exit(input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch exit_o: got %h, expected %h", got, exp);
      mismatches++;
    end
  endtask

  task automatic check_apb(input apb_req_t got, input apb_req_t exp);
    check_data("apb_req_o.paddr", got.paddr, exp.paddr);
    check_data("apb_req_o.pwdata", got.pwdata, exp.pwdata);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic add_vec(input kind_e kind, input addr_t addr, input data_t wdata,
                         input sel_t sel, input data_t rdata, input logic err);
    vecs.push_back('{kind, addr, wdata, sel, rdata, err});
  endtask

  task automatic build_table();
    // L2 full word, byte merge and aliasing
    add_vec(K_WRITE, L2Base + 32'h10, 32'h1234_5678, 4'hF, '0, 1'b0);
    add_vec(K_READ,  L2Base + 32'h10, '0, 4'hF, 32'h1234_5678, 1'b0);
    add_vec(K_WRITE, L2Base + 32'h10, 32'hAABB_CCDD, 4'b0101, '0, 1'b0);
    add_vec(K_READ,  L2Base + 32'h10, '0, 4'hF, 32'h12BB_56DD, 1'b0);
    add_vec(K_WRITE, L2Base + 32'h1040, 32'hCAFE_F00D, 4'hF, '0, 1'b0);
    add_vec(K_READ,  L2Base + 32'h40, '0, 4'hF, 32'hCAFE_F00D, 1'b0);
    add_vec(K_WRITE, L2Base, 32'h0F0F_F0F0, 4'hF, '0, 1'b0);
    // Control registers
    add_vec(K_READ,  CtrlBase + 32'h4, '0, 4'hF, 32'h8000_0000, 1'b0);
    add_vec(K_READ,  CtrlBase + 32'h8, '0, 4'hF, 32'hC000_0000, 1'b0);
    add_vec(K_WRITE, CtrlBase, 32'h0000_002A, 4'hF, '0, 1'b0);
    add_vec(K_EXIT,  '0, '0, '0, 32'h0000_002A, 1'b0);
    add_vec(K_READ,  CtrlBase, '0, 4'hF, 32'h0000_002A, 1'b0);
    add_vec(K_WRITE, CtrlBase + 32'h4, 32'hFFFF_FFFF, 4'hF, '0, 1'b0);
    add_vec(K_READ,  CtrlBase + 32'h4, '0, 4'hF, 32'h8000_0000, 1'b0);
    add_vec(K_READ,  CtrlBase + 32'h10, '0, 4'hF, 32'h0000_0000, 1'b0);
    // UART over APB
    add_vec(K_WRITE, UartBase + 32'h10, 32'h1357_9BDF, 4'h1, '0, 1'b0);
    add_vec(K_READ,  UartBase + 32'h10, '0, 4'hF, (UartBase + 32'h10) ^ PrdataMask, 1'b0);
    add_vec(K_READ,  UartBase + 32'h24, '0, 4'hF, (UartBase + 32'h24) ^ PrdataMask, 1'b0);
    add_vec(K_WRITE, UartBase + 32'h8, 32'h0000_00C3, 4'hF, '0, 1'b0);
    add_vec(K_READ,  UartBase + 32'h8, '0, 4'hF, (UartBase + 32'h8) ^ PrdataMask, 1'b0);
    // Error cases
    add_vec(K_READ,  UartBase + 32'hFFC, '0, 4'hF, (UartBase + 32'hFFC) ^ PrdataMask, 1'b1);
    add_vec(K_WRITE, UartBase + 32'hFFC, 32'h5555_AAAA, 4'hF, '0, 1'b1);
    add_vec(K_WRITE, 32'h1000_0000, 32'hDEAD_BEEF, 4'hF, '0, 1'b1);
    add_vec(K_READ,  32'h1000_0000, '0, 4'hF, 32'h0000_0000, 1'b1);
    add_vec(K_READ,  L2Base, '0, 4'hF, 32'h0F0F_F0F0, 1'b0);
    add_vec(K_EXIT,  '0, '0, '0, 32'h0000_002A, 1'b0);
  endtask

  // One access; the request stays up until the edge that takes the ack
  task automatic run_access(input vec_t v, output wb_rsp_t rsp, output logic done);
    int unsigned cycles;
    @(negedge clk_i);
    wb_req_i = '{cyc: 1'b1, stb: 1'b1, we: (v.kind == K_WRITE),
                 adr: v.addr, dat: v.wdata, sel: v.sel};
    cycles = 0;
    done   = 1'b0;
    rsp    = '0;
    while (!done && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      cycles++;
      if (wb_rsp_o.ack || wb_rsp_o.err) begin
        done = 1'b1;
        rsp  = wb_rsp_o;
      end
    end
    @(negedge clk_i);
    wb_req_i = '0;
  endtask

  initial begin
    vec_t     v;
    wb_rsp_t  rsp;
    logic     done;
    logic     in_uart;
    int       xfers_before;
    int       writes_before;
    apb_req_t exp_apb;
    void'($urandom(32'h62d0_6fc0));
    mismatches = 0;
    timeouts   = 0;
    rst_n_i    = 1'b0;
    wb_req_i   = '0;
    build_table();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle state after reset
    @(negedge clk_i);
    check_exit(exit_o, '0);
    check_err("apb_req_o.psel", apb_req_o.psel, 1'b0);
    check_err("wb_rsp_o.ack", wb_rsp_o.ack, 1'b0);
    check_err("wb_rsp_o.err", wb_rsp_o.err, 1'b0);

    foreach (vecs[i]) begin
      v = vecs[i];
      if (v.kind == K_EXIT) begin
        check_exit(exit_o, v.rdata);
      end else begin
        in_uart       = (v.addr >= UartBase) && ((v.addr - UartBase) < UartLength);
        xfers_before  = apb_xfers;
        writes_before = apb_writes.size();
        run_access(v, rsp, done);
        if (!done) begin
          $display("Timeout at entry %0d: no ack or err within %0d cycles", i,
                   TimeoutCycles);
          timeouts++;
        end else begin
          check_err("wb_rsp_o.err", rsp.err, v.err);
          check_err("wb_rsp_o.ack", rsp.ack, !v.err);
          if (v.kind == K_READ) begin
            check_data("wb_rsp_o.dat", rsp.dat, v.rdata);
          end
          check_err("apb_req_o.psel", apb_xfers != xfers_before, in_uart);
          if (in_uart) begin
            check_err("apb_req_o.pwrite", apb_writes.size() != writes_before,
                      v.kind == K_WRITE);
          end
          if (in_uart && v.kind == K_WRITE && apb_writes.size() != writes_before) begin
            exp_apb        = '0;
            exp_apb.paddr  = v.addr;
            exp_apb.pwdata = v.wdata;
            check_apb(apb_writes[apb_writes.size() - 1], exp_apb);
          end
        end
      end
    end

    $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : soc_tb

`default_nettype wire

// File: all.f
design/soc_pkg.sv
design/soc_xbar.sv
design/l2_mem.sv
design/wb_to_apb.sv
design/ctrl_registers.sv
design/soc_top.sv
sim/soc_props.sv
sim/soc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SoC interconnect testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module soc_tb -f all.f -o soc_tb_sim
./obj_dir/soc_tb_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
